//--- flist.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/instr_classifier.sv
logic/op_encoder.sv
logic/imm_gen.sv
logic/decode_stage.sv
verification/decode_stage_sva.sv
verification/decode_stage_tb.sv

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic [`RV_XLEN-1:0] i_instr,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic                i_slot2,      // Second issue slot, PC + 4
    input  logic                i_instr_vld,  // One-cycle strobe
    output decode_t             o_decode
);

    instr_class_t        instr_class;
    instr_op_e           instr_op;
    funct_e              funct;
    imm_fmt_e            imm_fmt;
    logic                class_ok;
    logic                use_imm;
    logic                use_pc;
    logic                wr_en;
    logic                prd_en;
    logic                ecall;
    logic                ebreak;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] slot_pc;
    decode_t             decode_next;

    instr_classifier u_classifier (
        .i_instr (i_instr),
        .o_class (instr_class)
    );

    op_encoder u_op_encoder (
        .i_class    (instr_class),
        .o_instr_op (instr_op),
        .o_funct    (funct),
        .o_imm_fmt  (imm_fmt),
        .o_class_ok (class_ok),
        .o_use_imm  (use_imm),
        .o_use_pc   (use_pc),
        .o_wr_en    (wr_en),
        .o_prd_en   (prd_en),
        .o_ecall    (ecall),
        .o_ebreak   (ebreak)
    );

    imm_gen u_imm_gen (
        .i_instr   (i_instr),
        .i_imm_fmt (imm_fmt),
        .o_imm     (imm)
    );

    assign slot_pc = i_slot2 ? i_pc + `RV_XLEN'(`RV_INSTR_BYTES) : i_pc;

    always_comb begin
        decode_next.funct    = funct;
        decode_next.instr_op = instr_op;
        decode_next.rs1_addr = i_instr[19:15];  // Raw fields, consumer ignores unused ones
        decode_next.rs2_addr = i_instr[24:20];
        decode_next.rd_addr  = i_instr[11:7];
        decode_next.use_imm  = use_imm;
        decode_next.use_pc   = use_pc;
        decode_next.imm      = imm;
        decode_next.pc       = slot_pc;
        decode_next.wr_en    = wr_en;
        decode_next.valid    = i_instr_vld & class_ok;
        decode_next.prd_en   = prd_en;
        decode_next.ecall    = ecall;
        decode_next.ebreak   = ebreak;
    end

    // Pipeline register, payload holds while the strobe is low
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_decode <= '0;
        end else if (i_instr_vld) begin
            o_decode <= decode_next;
        end else begin
            o_decode.valid <= 1'b0;  // One record per strobe
        end
    end

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    input  imm_fmt_e            i_imm_fmt,
    output logic [`RV_XLEN-1:0] o_imm
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_shift;
    logic [`RV_XLEN-1:0] imm_u;

    assign imm_i     = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s     = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b     = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                        i_instr[11:8], 1'b0};  // Halfword aligned offset
    assign imm_j     = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                        i_instr[30:21], 1'b0};
    assign imm_shift = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, i_instr[24:20]};  // Unsigned shamt
    assign imm_u     = {i_instr[31:12], 12'h000};  // LUI and AUIPC

    always_comb begin
        case (i_imm_fmt)
            IMM_I:     o_imm = imm_i;
            IMM_S:     o_imm = imm_s;
            IMM_B:     o_imm = imm_b;
            IMM_SHIFT: o_imm = imm_shift;
            IMM_U:     o_imm = imm_u;
            IMM_J:     o_imm = imm_j;
            default:   o_imm = '0;  // OP, SYSTEM and illegal words
        endcase
    end

endmodule

`default_nettype wire

//--- logic/instr_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module instr_classifier
    import rv_decode_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    output instr_class_t        o_class
);

    opcode_e                opcode;
    logic [6:0]             funct7;
    logic [`RV_SHAMT_W-1:0] shamt;

    assign opcode = opcode_e'(i_instr[`RV_OPCODE_W-1:0]);  // Unlisted codes match no group
    assign funct7 = i_instr[31:25];
    assign shamt  = i_instr[24:20];

    // Opcode groups, at most one flag set per word
    always_comb begin
        o_class.is_load   = (opcode == OPC_LOAD);
        o_class.is_store  = (opcode == OPC_STORE);
        o_class.is_branch = (opcode == OPC_BRANCH);
        o_class.is_op_imm = (opcode == OPC_OP_IMM);
        o_class.is_op     = (opcode == OPC_OP);
        o_class.is_system = (opcode == OPC_SYSTEM);
        o_class.is_jal    = (opcode == OPC_JAL);
        o_class.is_jalr   = (opcode == OPC_JALR);
        o_class.is_lui    = (opcode == OPC_LUI);
        o_class.is_auipc  = (opcode == OPC_AUIPC);
    end

    always_comb begin
        o_class.funct3       = i_instr[14:12];
        o_class.f7_zero      = (funct7 == 7'b000_0000);
        o_class.f7_alt       = (funct7 == 7'b010_0000);  // SUB and SRA marker
        o_class.shamt_hi_one = (shamt == `RV_SHAMT_W'(1));
    end

endmodule

`default_nettype wire

//--- logic/op_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_encoder
    import rv_decode_pkg::*;
(
    input  instr_class_t i_class,
    output instr_op_e    o_instr_op,
    output funct_e       o_funct,
    output imm_fmt_e     o_imm_fmt,
    output logic         o_class_ok,
    output logic         o_use_imm,
    output logic         o_use_pc,
    output logic         o_wr_en,
    output logic         o_prd_en,
    output logic         o_ecall,
    output logic         o_ebreak
);

    logic is_shift;

    // Shared ALU mapping for OP and OP_IMM
    // Register forms check funct7 on every operation, immediate forms only on shifts
    function automatic instr_op_e alu_op(
        input logic [2:0] f3,
        input logic       f7_zero,
        input logic       f7_alt,
        input logic       is_reg
    );
        instr_op_e op;
        logic      f7_std;
        op     = ADD;
        f7_std = f7_zero | ~is_reg;
        case (f3)
            3'b000: if (is_reg && f7_alt) op = SUB;
            3'b001: if (f7_zero) op = SLL;
            3'b010: if (f7_std) op = SLT;
            3'b011: if (f7_std) op = SLTU;
            3'b100: if (f7_std) op = XOR;
            3'b101: begin
                if (f7_zero) op = SRL;
                else if (f7_alt) op = SRA;
            end
            3'b110: if (f7_std) op = OR;
            default: if (f7_std) op = AND;
        endcase
        return op;
    endfunction

    assign is_shift = (i_class.funct3 == 3'b001) || (i_class.funct3 == 3'b101);

    always_comb begin
        o_funct    = NONE;  // SYSTEM and unknown opcodes
        o_instr_op = ADD;   // Fallback for unmatched patterns
        o_imm_fmt  = IMM_NONE;
        case (1'b1)
            i_class.is_load: begin
                o_funct   = LOAD;
                o_imm_fmt = IMM_I;
                case (i_class.funct3)
                    3'b000:  o_instr_op = LB;
                    3'b001:  o_instr_op = LH;
                    3'b010:  o_instr_op = LW;
                    3'b100:  o_instr_op = LBU;
                    3'b101:  o_instr_op = LHU;
                    default: o_instr_op = ADD;
                endcase
            end
            i_class.is_store: begin
                o_funct   = STORE;
                o_imm_fmt = IMM_S;
                case (i_class.funct3)
                    3'b000:  o_instr_op = SB;
                    3'b001:  o_instr_op = SH;
                    3'b010:  o_instr_op = SW;
                    default: o_instr_op = ADD;
                endcase
            end
            i_class.is_branch: begin
                o_funct   = CTRL_TRNSF;
                o_imm_fmt = IMM_B;
                case (i_class.funct3)
                    3'b000:  o_instr_op = BEQ;
                    3'b001:  o_instr_op = BNE;
                    3'b100:  o_instr_op = BLT;
                    3'b101:  o_instr_op = BGE;
                    3'b110:  o_instr_op = BLTU;
                    3'b111:  o_instr_op = BGEU;
                    default: o_instr_op = ADD;
                endcase
            end
            i_class.is_op_imm: begin
                o_funct    = ALU;
                o_imm_fmt  = is_shift ? IMM_SHIFT : IMM_I;  // Format follows funct3 alone
                o_instr_op = alu_op(i_class.funct3, i_class.f7_zero, i_class.f7_alt, 1'b0);
            end
            i_class.is_op: begin
                o_funct    = ALU;
                o_instr_op = alu_op(i_class.funct3, i_class.f7_zero, i_class.f7_alt, 1'b1);
            end
            i_class.is_jal: begin
                o_funct    = CTRL_TRNSF;
                o_imm_fmt  = IMM_J;
                o_instr_op = JAL;
            end
            i_class.is_jalr: begin
                o_funct    = CTRL_TRNSF;
                o_imm_fmt  = IMM_I;
                o_instr_op = JALR;
            end
            i_class.is_lui: begin
                o_funct    = ALU;
                o_imm_fmt  = IMM_U;
                o_instr_op = LUI;
            end
            i_class.is_auipc: begin
                o_funct    = ALU;
                o_imm_fmt  = IMM_U;
                o_instr_op = AUIPC;
            end
            default: ;
        endcase
    end

    assign o_class_ok = (o_funct != NONE);
    assign o_prd_en   = (o_funct == CTRL_TRNSF);
    assign o_use_pc   = i_class.is_auipc | i_class.is_jal | i_class.is_branch;
    assign o_use_imm  = i_class.is_auipc | i_class.is_jal | i_class.is_jalr | i_class.is_lui |
                        i_class.is_load | i_class.is_op_imm | i_class.is_store |
                        i_class.is_branch;
    assign o_wr_en    = i_class.is_auipc | i_class.is_jal | i_class.is_jalr | i_class.is_lui |
                        i_class.is_load | i_class.is_op_imm | i_class.is_op;
    assign o_ebreak   = i_class.is_system & (i_class.funct3 == 3'b000) & i_class.shamt_hi_one;
    assign o_ecall    = i_class.is_system & ~o_ebreak;  // Never together with ebreak

endmodule

`default_nettype wire

//--- logic/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Datapath and PC width
`define RV_XLEN         32

// Register file address width
`define RV_REG_AW       5

// Major opcode field instr[6:0]
`define RV_OPCODE_W     7

// Shift amount field instr[24:20]
`define RV_SHAMT_W      5

// Instruction size, step to the second issue slot
`define RV_INSTR_BYTES  4

`endif

//--- logic/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

    typedef enum logic [`RV_OPCODE_W-1:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_SYSTEM = 7'b111_0011,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111
    } opcode_e;

    // NONE sits at zero so a cleared record reads as no class
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_TRNSF
    } funct_e;

    typedef enum logic [4:0] {
        ADD, SUB, XOR, OR, AND,               // 0 - 4
        SRL, SRA, SLL, SLT, SLTU,             // 5 - 9
        BEQ, BNE, BLT, BGE, BLTU, BGEU,       // 10 - 15
        LB, LH, LW, LBU, LHU,                 // 16 - 20
        SB, SH, SW,                           // 21 - 23
        JAL, JALR, LUI, AUIPC                 // 24 - 27
    } instr_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_SHIFT,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_op_imm;
        logic       is_op;
        logic       is_system;
        logic       is_jal;
        logic       is_jalr;
        logic       is_lui;
        logic       is_auipc;
        logic [2:0] funct3;
        logic       f7_zero;       // funct7 == 7'b000_0000
        logic       f7_alt;        // funct7 == 7'b010_0000
        logic       shamt_hi_one;  // instr[24:20] == 1, ebreak pattern
    } instr_class_t;

    typedef struct packed {
        funct_e                funct;
        instr_op_e             instr_op;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic [`RV_REG_AW-1:0] rs2_addr;
        logic [`RV_REG_AW-1:0] rd_addr;
        logic                  use_imm;
        logic                  use_pc;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_XLEN-1:0]   pc;
        logic                  wr_en;
        logic                  valid;
        logic                  prd_en;
        logic                  ecall;
        logic                  ebreak;
    } decode_t;

endpackage

`default_nettype wire

//--- verification/decode_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva
    import rv_decode_pkg::*;
(
    input logic    i_clk,
    input logic    i_reset,
    input decode_t i_decode
);

    // A valid record always has a class
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_decode.valid |-> (i_decode.funct != NONE))
        else $error("valid record with funct NONE");

    assert property (@(posedge i_clk) disable iff (i_reset)
        i_decode.prd_en == (i_decode.funct == CTRL_TRNSF))
        else $error("prd_en does not follow CTRL_TRNSF class");

    assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_decode.ecall && i_decode.ebreak))
        else $error("ecall and ebreak both high");

    assert property (@(posedge i_clk) i_reset |=> !i_decode.valid)  // Cleared by reset
        else $error("valid high in the cycle after reset");

endmodule

bind decode_stage decode_stage_sva u_decode_stage_sva (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_decode (o_decode)
);

`default_nettype wire

//--- verification/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module decode_stage_tb
    import rv_decode_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 2000;                           // One instruction per cycle
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_CYCLES + 84;  // Drain plus margin, 2100

    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
    logic                slot2;
    logic                instr_vld;
    decode_t             decode;

    decode_t             exp_queue[$];
    decode_t             exp_rec;      // What o_decode should hold this cycle
    int                  cycle_count = 0;
    int                  check_count = 0;
    int                  error_count = 0;
    int                  strobe_count = 0;
    opcode_e             opc_table[10] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_OP_IMM, OPC_OP,
                                           OPC_SYSTEM, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};

    decode_stage i_decode_stage (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_instr     (instr),
        .i_pc        (pc),
        .i_slot2     (slot2),
        .i_instr_vld (instr_vld),
        .o_decode    (decode)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected record built from the RV32I encoding rules
    function automatic decode_t model_decode(input logic [31:0] w, input logic [31:0] p,
                                             input logic slot, input logic vld);
        decode_t    d;
        logic [2:0] f3;
        logic [6:0] f7;
        instr_op_e  base_op;
        d  = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        d.rs1_addr = w[19:15];
        d.rs2_addr = w[24:20];
        d.rd_addr  = w[11:7];
        d.pc       = slot ? p + 32'd4 : p;
        case (f3)                                   // Plain funct3 meaning for ALU forms
            3'd0: base_op = ADD;
            3'd1: base_op = SLL;
            3'd2: base_op = SLT;
            3'd3: base_op = SLTU;
            3'd4: base_op = XOR;
            3'd5: base_op = SRL;
            3'd6: base_op = OR;
            default: base_op = AND;
        endcase
        case (w[6:0])
            OPC_LOAD: begin
                d.funct = LOAD;
                d.imm = `RV_XLEN'($signed(w[31:20]));
                d.instr_op = f3 == 0 ? LB : f3 == 1 ? LH : f3 == 2 ? LW :
                             f3 == 4 ? LBU : f3 == 5 ? LHU : ADD;
            end
            OPC_STORE: begin
                d.funct = STORE;
                d.imm = `RV_XLEN'($signed({w[31:25], w[11:7]}));
                d.instr_op = f3 == 0 ? SB : f3 == 1 ? SH : f3 == 2 ? SW : ADD;
            end
            OPC_BRANCH: begin
                d.funct = CTRL_TRNSF;
                d.imm = `RV_XLEN'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                d.instr_op = f3 == 0 ? BEQ : f3 == 1 ? BNE : f3 == 4 ? BLT :
                             f3 == 5 ? BGE : f3 == 6 ? BLTU : f3 == 7 ? BGEU : ADD;
            end
            OPC_OP_IMM: begin
                d.funct = ALU;
                d.instr_op = base_op;
                d.imm = `RV_XLEN'($signed(w[31:20]));
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    d.imm = {27'd0, w[24:20]};      // Shift amount, no sign
                    if (f7 == 7'h20 && f3 == 3'd5) d.instr_op = SRA;
                    else if (f7 != 7'h00) d.instr_op = ADD;
                end
            end
            OPC_OP: begin
                d.funct = ALU;
                d.instr_op = base_op;
                if (f7 == 7'h20 && f3 == 3'd0) d.instr_op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5) d.instr_op = SRA;
                else if (f7 != 7'h00) d.instr_op = ADD;
            end
            OPC_JAL: begin
                d.funct = CTRL_TRNSF;
                d.instr_op = JAL;
                d.imm = `RV_XLEN'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            end
            OPC_JALR: begin
                d.funct = CTRL_TRNSF;
                d.instr_op = JALR;
                d.imm = `RV_XLEN'($signed(w[31:20]));
            end
            OPC_LUI, OPC_AUIPC: begin
                d.funct = ALU;
                d.instr_op = (w[6:0] == OPC_LUI) ? LUI : AUIPC;
                d.imm = {w[31:12], 12'd0};
            end
            OPC_SYSTEM: begin
                d.ebreak = (f3 == 3'd0) && (w[24:20] == 5'd1);
                d.ecall  = !d.ebreak;
            end
            default: ;
        endcase
        d.use_pc  = w[6:0] inside {OPC_AUIPC, OPC_JAL, OPC_BRANCH};
        d.use_imm = w[6:0] inside {OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LUI, OPC_LOAD,
                                   OPC_OP_IMM, OPC_STORE, OPC_BRANCH};
        d.wr_en   = w[6:0] inside {OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LUI, OPC_LOAD,
                                   OPC_OP_IMM, OPC_OP};
        d.prd_en  = (d.funct == CTRL_TRNSF);
        d.valid   = vld && (d.funct != NONE);
        return d;
    endfunction

    // Legal encoding from the opcode table, or one word in five fully random
    function automatic logic [31:0] random_word();
        opcode_e    opc;
        logic [6:0] f7;
        logic [4:0] rs2;
        if ($urandom_range(0, 4) == 0) return $urandom();
        opc = opc_table[$urandom_range(0, 9)];
        case ($urandom_range(0, 2))
            0: f7 = 7'h00;
            1: f7 = 7'h20;
            default: f7 = 7'($urandom());     // Immediate bits incl. sign
        endcase
        rs2 = 5'($urandom());
        if (opc == OPC_SYSTEM && $urandom_range(0, 1) == 1) rs2 = 5'd1;  // Reach ebreak
        return {f7, rs2, 5'($urandom()), 3'($urandom()), 5'($urandom()), opc};
    endfunction

    task automatic count_error();
        error_count++;
    endtask

    task automatic check_op(input string name, input instr_op_e exp, input instr_op_e act);
        check_count++;
        if (act !== exp) begin
            count_error();
            $display("error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_funct(input string name, input funct_e exp, input funct_e act);
        check_count++;
        if (act !== exp) begin
            count_error();
            $display("error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`RV_XLEN-1:0] exp,
                              input logic [`RV_XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            count_error();
            $display("error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`RV_REG_AW-1:0] exp,
                              input logic [`RV_REG_AW-1:0] act);
        check_count++;
        if (act !== exp) begin
            count_error();
            $display("error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            count_error();
            $display("error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic compare_record(input decode_t exp, input decode_t act);
        check_funct("o_decode.funct", exp.funct, act.funct);
        check_op("o_decode.instr_op", exp.instr_op, act.instr_op);
        check_addr("o_decode.rs1_addr", exp.rs1_addr, act.rs1_addr);
        check_addr("o_decode.rs2_addr", exp.rs2_addr, act.rs2_addr);
        check_addr("o_decode.rd_addr", exp.rd_addr, act.rd_addr);
        check_word("o_decode.imm", exp.imm, act.imm);
        check_word("o_decode.pc", exp.pc, act.pc);
        check_flag("o_decode.use_imm", exp.use_imm, act.use_imm);
        check_flag("o_decode.use_pc", exp.use_pc, act.use_pc);
        check_flag("o_decode.wr_en", exp.wr_en, act.wr_en);
        check_flag("o_decode.valid", exp.valid, act.valid);
        check_flag("o_decode.prd_en", exp.prd_en, act.prd_en);
        check_flag("o_decode.ecall", exp.ecall, act.ecall);
        check_flag("o_decode.ebreak", exp.ebreak, act.ebreak);
    endtask

    // Track what the register loaded at the edge, check it mid-cycle
    always begin
        @(posedge clk);
        if (reset) begin
            exp_rec = '0;
        end else if (instr_vld) begin
            if (exp_queue.size() == 0) begin
                count_error();
                $display("strobe seen with no expected record queued");
            end else begin
                exp_rec = exp_queue.pop_front();
            end
        end else begin
            exp_rec.valid = 1'b0;                  // Payload holds
        end
        @(negedge clk);
        compare_record(exp_rec, decode);
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        instr     = '0;
        pc        = '0;
        slot2     = 1'b0;
        instr_vld = 1'b0;
        exp_rec   = '0;
        void'($urandom(32'hcd5));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #1;
            instr     = random_word();
            pc        = {$urandom() & 32'hffff_fffc};
            slot2     = 1'($urandom());
            instr_vld = ($urandom_range(0, 9) < 7);  // About 70 percent
            if (instr_vld) begin
                exp_queue.push_back(model_decode(instr, pc, slot2, 1'b1));
                strobe_count++;
            end
        end
        @(posedge clk);
        #1;
        instr_vld = 1'b0;
        repeat (3) @(posedge clk);
        if (exp_queue.size() != 0) begin
            count_error();
            $display("%0d expected records were never consumed", exp_queue.size());
        end
        $display("strobes %0d, checks %0d, errors %0d", strobe_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
